/* logic/sram_cfg_pkg.sv */
package sram_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // chip variant: 23LC512, 64 KB
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int addr_bits  = 16;
    localparam int addr_bytes = addr_bits / 8;

    localparam logic [7:0] cmd_read  = 8'h03;
    localparam logic [7:0] cmd_write = 8'h02;
    localparam logic [7:0] cmd_eqio  = 8'h38;   // enter quad io

    localparam int dummy_bytes = 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int sck_div    = 4;   // clk cycles per sck half period
    localparam int fifo_depth = 8;
    localparam int cmd_depth  = 2;
    localparam int test_words = 4;

endpackage

/* logic/sram_if_pkg.sv */
package sram_if_pkg;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic        write;
        logic [5:0]  size;    // in words
        logic [23:0] addr;
    } sram_cmd_t;

    typedef enum logic [2:0] {
        ph_init,
        ph_idle,
        ph_opcode,
        ph_addr,
        ph_dummy,
        ph_wdata,
        ph_rdata,
        ph_finish
    } seq_phase_t;

    typedef struct packed {
        logic [7:0] data;
        logic       quad;     // 4 bits per edge
        logic       drive;    // master owns the bus
        logic       last;     // release cs after this byte
    } shift_req_t;

endpackage

/* logic/word_fifo.sv */
`timescale 1ns/10ps

module word_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  payload_t                     din,
    input  logic                         pop,
    output payload_t                     dout,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(depth+1)-1:0]   count
);
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    payload_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign empty   = (count == '0);
    assign full    = (count == ($clog2(depth+1))'(depth));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];   // show-ahead

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* logic/qspi_shifter.sv */
`timescale 1ns/10ps

module qspi_shifter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    go,
    input  sram_if_pkg::shift_req_t req,
    output logic                    byte_done,
    output logic [7:0]              rx_byte,
    output logic                    cs,
    output logic                    sck,
    output logic [3:0]              sio_o,
    output logic [3:0]              sio_oe,
    input  logic [3:0]              sio_i
);
    localparam int div_w = (sram_cfg_pkg::sck_div > 1) ? $clog2(sram_cfg_pkg::sck_div) : 1;

    logic             busy;
    logic [div_w-1:0] div_cnt;
    logic [3:0]       edge_cnt;   // sck edges in this byte
    logic             quad;
    logic             last;
    logic [7:0]       tx;
    logic             tick;
    logic             last_edge;
    logic             start;

    assign start     = go && !busy;
    assign tick      = busy && (div_cnt == div_w'(sram_cfg_pkg::sck_div - 1));
    assign last_edge = (edge_cnt == (quad ? 4'd3 : 4'd15));
    assign byte_done = tick && last_edge;
    assign sio_o     = quad ? tx[7:4] : {3'b000, tx[7]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            cs       <= 1'b1;
            sck      <= 1'b0;
            sio_oe   <= 4'b0000;
            quad     <= 1'b0;
            last     <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            div_cnt  <= '0;
            edge_cnt <= '0;
            cs       <= 1'b0;
            quad     <= req.quad;
            last     <= req.last;
            if (!req.drive) begin
                sio_oe <= 4'b0000;
            end else begin
                sio_oe <= req.quad ? 4'b1111 : 4'b0001;
            end
        end else if (tick) begin
            div_cnt  <= '0;
            edge_cnt <= edge_cnt + 1'b1;
            sck      <= ~sck;
            if (last_edge) begin
                busy <= 1'b0;
                if (last) begin
                    cs     <= 1'b1;
                    sio_oe <= 4'b0000;
                end
            end
        end else if (busy) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // first bits go out with go, the rest on falling sck
    always_ff @(posedge clk) begin
        if (start) begin
            tx <= req.data;
        end else if (tick && sck) begin
            tx <= quad ? {tx[3:0], 4'h0} : {tx[6:0], 1'b0};
        end else if (tick && !sck) begin
            rx_byte <= quad ? {rx_byte[3:0], sio_i} : {rx_byte[6:0], sio_i[1]};   // SO in spi
        end
    end

endmodule

/* logic/sram_sequencer.sv */
`timescale 1ns/10ps

module sram_sequencer (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  sram_if_pkg::sram_cmd_t                        cmd,
    input  logic                                          cmd_empty,
    output logic                                          cmd_pop,
    input  sram_if_pkg::word_t                            wr_word,
    output logic                                          wr_pop,
    output sram_if_pkg::word_t                            rd_word,
    output logic                                          rd_push,
    input  logic [$clog2(sram_cfg_pkg::fifo_depth+1)-1:0] rd_count,
    output logic                                          done,
    output sram_if_pkg::shift_req_t                       shift_req,
    output logic                                          go,
    input  logic                                          byte_done,
    input  logic [7:0]                                    rx_byte
);
    sram_if_pkg::seq_phase_t phase;
    sram_if_pkg::sram_cmd_t  cur;
    logic                    pend;       // byte handed to the shifter
    logic [7:0]              cnt;        // byte count within a phase
    logic [23:0]             acc;
    logic                    room;
    logic                    word_end;
    logic                    data_end;

    // a read waits until its whole burst fits in the read fifo
    assign room     = cmd.write ||
                      (int'(rd_count) + int'(cmd.size) <= sram_cfg_pkg::fifo_depth);
    assign cmd_pop  = (phase == sram_if_pkg::ph_idle) && !cmd_empty && room;
    assign done     = (phase == sram_if_pkg::ph_idle) && cmd_empty;
    assign go       = !pend && (phase != sram_if_pkg::ph_idle) &&
                      (phase != sram_if_pkg::ph_finish);
    assign word_end = (cnt[1:0] == 2'd3);
    assign data_end = (cnt == {cur.size, 2'b00} - 8'd1);
    assign wr_pop   = byte_done && (phase == sram_if_pkg::ph_wdata) && word_end;
    assign rd_push  = byte_done && (phase == sram_if_pkg::ph_rdata) && word_end;
    assign rd_word  = {acc, rx_byte};   // msb first

    always_comb begin
        shift_req = '{data: 8'h00, quad: 1'b1, drive: 1'b0, last: 1'b0};
        case (phase)
            sram_if_pkg::ph_init: begin
                shift_req = '{data: sram_cfg_pkg::cmd_eqio, quad: 1'b0, drive: 1'b1, last: 1'b1};
            end
            sram_if_pkg::ph_opcode: begin
                shift_req.data  = cur.write ? sram_cfg_pkg::cmd_write : sram_cfg_pkg::cmd_read;
                shift_req.drive = 1'b1;
            end
            sram_if_pkg::ph_addr: begin
                shift_req.data  = 8'(cur.addr >> (8 * (sram_cfg_pkg::addr_bytes - 1 - int'(cnt))));
                shift_req.drive = 1'b1;
            end
            sram_if_pkg::ph_wdata: begin
                shift_req.data  = 8'(wr_word >> (8 * (3 - int'(cnt[1:0]))));
                shift_req.drive = 1'b1;
                shift_req.last  = data_end;
            end
            sram_if_pkg::ph_rdata: shift_req.last = data_end;
            default: ;   // dummy clocks with the bus released
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= sram_if_pkg::ph_init;
            pend  <= 1'b0;
            cnt   <= '0;
        end else begin
            if (go) begin
                pend <= 1'b1;
            end else if (byte_done) begin
                pend <= 1'b0;
            end
            case (phase)
                sram_if_pkg::ph_idle: begin
                    if (cmd_pop) begin
                        phase <= sram_if_pkg::ph_opcode;
                        cnt   <= '0;
                    end
                end
                sram_if_pkg::ph_finish: phase <= sram_if_pkg::ph_idle;
                default: begin
                    if (byte_done) begin
                        cnt <= cnt + 1'b1;
                        case (phase)
                            sram_if_pkg::ph_init:   phase <= sram_if_pkg::ph_idle;
                            sram_if_pkg::ph_opcode: begin
                                phase <= sram_if_pkg::ph_addr;
                                cnt   <= '0;
                            end
                            sram_if_pkg::ph_addr: begin
                                if (cnt == 8'(sram_cfg_pkg::addr_bytes - 1)) begin
                                    phase <= cur.write ? sram_if_pkg::ph_wdata
                                                       : sram_if_pkg::ph_dummy;
                                    cnt   <= '0;
                                end
                            end
                            sram_if_pkg::ph_dummy: begin
                                if (cnt == 8'(sram_cfg_pkg::dummy_bytes - 1)) begin
                                    phase <= sram_if_pkg::ph_rdata;
                                    cnt   <= '0;
                                end
                            end
                            default: if (data_end) phase <= sram_if_pkg::ph_finish;
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            cur <= cmd;
        end
        if (byte_done && (phase == sram_if_pkg::ph_rdata)) begin
            acc <= {acc[15:0], rx_byte};
        end
    end

endmodule

/* logic/spi_sram_fifo.sv */
`timescale 1ns/10ps

module spi_sram_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sram_if_pkg::word_t     wr_data,
    input  logic                   wr_valid,
    input  sram_if_pkg::sram_cmd_t cmd,
    input  logic                   cmd_valid,
    output sram_if_pkg::word_t     rd_data,
    input  logic                   rd_pop,
    output logic                   rd_empty,
    output logic                   done,
    output logic                   cs,
    output logic                   sck,
    output logic [3:0]             sio_o,
    output logic [3:0]             sio_oe,
    input  logic [3:0]             sio_i
);
    sram_if_pkg::sram_cmd_t  cmd_head;
    logic                    cmd_empty;
    logic                    cmd_full;
    logic                    cmd_pop;
    sram_if_pkg::word_t      wr_word;
    logic                    wr_full;
    logic                    wr_pop;
    sram_if_pkg::word_t      rd_word;
    logic                    rd_full;
    logic                    rd_push;
    logic [$clog2(sram_cfg_pkg::fifo_depth+1)-1:0] rd_count;
    sram_if_pkg::shift_req_t shift_req;
    logic                    go;
    logic                    byte_done;
    logic [7:0]              rx_byte;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queues
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    word_fifo #(.payload_t(sram_if_pkg::sram_cmd_t), .depth(sram_cfg_pkg::cmd_depth)) u_cmd_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(cmd_valid), .din(cmd),
        .pop(cmd_pop), .dout(cmd_head),
        .empty(cmd_empty), .full(cmd_full), .count()
    );

    word_fifo #(.payload_t(sram_if_pkg::word_t), .depth(sram_cfg_pkg::fifo_depth)) u_wr_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(wr_valid), .din(wr_data),
        .pop(wr_pop), .dout(wr_word),
        .empty(), .full(wr_full), .count()
    );

    word_fifo #(.payload_t(sram_if_pkg::word_t), .depth(sram_cfg_pkg::fifo_depth)) u_rd_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(rd_push), .din(rd_word),
        .pop(rd_pop), .dout(rd_data),
        .empty(rd_empty), .full(rd_full), .count(rd_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command engine and serial port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    sram_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .cmd(cmd_head), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
        .wr_word(wr_word), .wr_pop(wr_pop),
        .rd_word(rd_word), .rd_push(rd_push), .rd_count(rd_count),
        .done(done),
        .shift_req(shift_req), .go(go),
        .byte_done(byte_done), .rx_byte(rx_byte)
    );

    qspi_shifter u_shift (
        .clk(clk), .rst_n(rst_n),
        .go(go), .req(shift_req),
        .byte_done(byte_done), .rx_byte(rx_byte),
        .cs(cs), .sck(sck),
        .sio_o(sio_o), .sio_oe(sio_oe), .sio_i(sio_i)
    );

endmodule

/* logic/sram_self_test.sv */
`timescale 1ns/10ps

module sram_self_test (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [23:0]            base_addr,
    input  sram_if_pkg::word_t     pattern,
    output logic                   busy,
    output logic                   pass,
    output logic                   fail,
    output sram_if_pkg::word_t     wr_data,
    output logic                   wr_valid,
    output sram_if_pkg::sram_cmd_t cmd,
    output logic                   cmd_valid,
    input  sram_if_pkg::word_t     rd_data,
    output logic                   rd_pop,
    input  logic                   rd_empty
);
    typedef enum logic [2:0] {st_idle, st_push, st_wcmd, st_rcmd, st_check} st_t;

    st_t                state;
    logic [23:0]        addr_q;
    sram_if_pkg::word_t pattern_q;
    logic [5:0]         idx;
    logic               err;         // a mismatch seen earlier in this run
    sram_if_pkg::word_t expected;
    logic               last_word;
    logic               miss;

    assign expected  = pattern_q + sram_if_pkg::word_t'(idx);   // wraps at 32 bits
    assign last_word = (idx == 6'(sram_cfg_pkg::test_words - 1));
    assign miss      = (rd_data != expected);
    assign wr_valid  = (state == st_push);
    assign wr_data   = expected;
    assign cmd_valid = (state == st_wcmd) || (state == st_rcmd);
    assign cmd       = '{write: (state == st_wcmd), size: 6'(sram_cfg_pkg::test_words),
                         addr: addr_q};
    assign rd_pop    = (state == st_check) && !rd_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            busy  <= 1'b0;
            pass  <= 1'b0;
            fail  <= 1'b0;
            idx   <= '0;
            err   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_push;
                        busy  <= 1'b1;
                        pass  <= 1'b0;
                        fail  <= 1'b0;
                        idx   <= '0;
                        err   <= 1'b0;
                    end
                end
                st_push: begin
                    idx <= last_word ? '0 : idx + 1'b1;
                    if (last_word) state <= st_wcmd;
                end
                st_wcmd: state <= st_rcmd;
                st_rcmd: state <= st_check;
                default: begin
                    // every word is drained so the next run starts clean
                    if (!rd_empty) begin
                        idx <= idx + 1'b1;
                        if (miss) err <= 1'b1;
                        if (last_word) begin
                            state <= st_idle;
                            busy  <= 1'b0;
                            pass  <= !err && !miss;
                            fail  <= err || miss;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            addr_q    <= base_addr;
            pattern_q <= pattern;
        end
    end

endmodule

/* logic/sram_test_top.sv */
`timescale 1ns/10ps

module sram_test_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [23:0]        base_addr,
    input  sram_if_pkg::word_t pattern,
    output logic               busy,
    output logic               pass,
    output logic               fail,
    output logic               cs,
    output logic               sck,
    output logic [3:0]         sio_o,
    output logic [3:0]         sio_oe,
    input  logic [3:0]         sio_i
);
    sram_if_pkg::word_t     wr_data;
    logic                   wr_valid;
    sram_if_pkg::sram_cmd_t cmd;
    logic                   cmd_valid;
    sram_if_pkg::word_t     rd_data;
    logic                   rd_pop;
    logic                   rd_empty;

    sram_self_test u_bist (
        .clk(clk), .rst_n(rst_n),
        .start(start), .base_addr(base_addr), .pattern(pattern),
        .busy(busy), .pass(pass), .fail(fail),
        .wr_data(wr_data), .wr_valid(wr_valid),
        .cmd(cmd), .cmd_valid(cmd_valid),
        .rd_data(rd_data), .rd_pop(rd_pop), .rd_empty(rd_empty)
    );

    spi_sram_fifo u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .wr_data(wr_data), .wr_valid(wr_valid),
        .cmd(cmd), .cmd_valid(cmd_valid),
        .rd_data(rd_data), .rd_pop(rd_pop), .rd_empty(rd_empty),
        .done(),     // self-test paces itself on the read fifo
        .cs(cs), .sck(sck),
        .sio_o(sio_o), .sio_oe(sio_oe), .sio_i(sio_i)
    );

endmodule

/* verif/qspi_sram_model.sv */
`timescale 1ns/10ps

module qspi_sram_model (
    input  logic       cs,
    input  logic       sck,
    input  logic [3:0] sio_o,
    input  logic [3:0] sio_oe,
    output logic [3:0] sio_i,
    input  logic       flip_req,   // corrupt the next written burst
    input  logic [4:0] flip_bit
);
    localparam int hdr_bytes = 1 + sram_cfg_pkg::addr_bytes;
    localparam int rd_bits   = (hdr_bytes + sram_cfg_pkg::dummy_bytes) * 8;

    logic [7:0]  mem [int];   // sparse, keyed by 16-bit address
    logic        quad_mode;
    logic [7:0]  shreg;
    logic [7:0]  opcode;
    logic [15:0] addr;
    int          bit_cnt;
    int          byte_cnt;
    int          n_eqio;
    int          n_write;
    int          n_read;
    logic [7:0]  first_byte;
    logic [3:0]  first_oe;    // lanes the master drove for the first byte
    logic        got_first;

    initial begin
        quad_mode = 1'b0;
        got_first = 1'b0;
        opcode    = 8'h00;
        addr      = '0;
        bit_cnt   = 0;
        byte_cnt  = 0;
        n_eqio    = 0;
        n_write   = 0;
        n_read    = 0;
        sio_i     = 4'h0;
    end

    function automatic logic [7:0] read_byte(input int a);
        int k;
        k = a & 16'hffff;
        if (mem.exists(k)) begin
            return mem[k];
        end
        return 8'h00;
    endfunction

    task automatic take_byte(input logic [7:0] b);
        if (!got_first) begin
            first_byte = b;
            first_oe   = sio_oe;
            got_first  = 1'b1;
        end
        if (!quad_mode) begin
            if (b == sram_cfg_pkg::cmd_eqio) begin
                quad_mode = 1'b1;
                n_eqio++;
            end
        end else if (byte_cnt == 0) begin
            opcode = b;
            if (b == sram_cfg_pkg::cmd_write) n_write++;
            if (b == sram_cfg_pkg::cmd_read) n_read++;
        end else if (byte_cnt < hdr_bytes) begin
            addr = {addr[7:0], b};   // msb first
        end else if (opcode == sram_cfg_pkg::cmd_write) begin
            mem[(int'(addr) + byte_cnt - hdr_bytes) & 16'hffff] = b;
        end
        byte_cnt++;
    endtask

    always @(posedge sck or posedge cs) begin
        if (cs) begin
            // end of a transaction
            if (flip_req && opcode == sram_cfg_pkg::cmd_write && byte_cnt > hdr_bytes) begin
                mem[(int'(addr) + 3 - int'(flip_bit) / 8) & 16'hffff] ^=
                    8'(1 << (int'(flip_bit) % 8));
            end
            bit_cnt  = 0;
            byte_cnt = 0;
            opcode   = 8'h00;
            sio_i   <= 4'h0;
        end else begin
            // only enabled lanes reach the chip
            if (quad_mode) begin
                shreg   = {shreg[3:0], sio_o & sio_oe};
                bit_cnt = bit_cnt + 4;
            end else begin
                shreg   = {shreg[6:0], sio_o[0] & sio_oe[0]};
                bit_cnt = bit_cnt + 1;
            end
            if (bit_cnt % 8 == 0) take_byte(shreg);
            // next read nibble is ready before the next rising sck
            if (quad_mode && opcode == sram_cfg_pkg::cmd_read && bit_cnt >= rd_bits) begin
                shreg = read_byte(int'(addr) + (bit_cnt - rd_bits) / 8);
                sio_i <= (((bit_cnt - rd_bits) / 4) % 2 == 1) ? shreg[3:0] : shreg[7:4];
            end
        end
    end

endmodule

/* verif/sram_assertions.sv */
`timescale 1ns/10ps

module sram_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       cs,
    input logic       sck,
    input logic [3:0] sio_oe,
    input logic       cmd_push,
    input logic       cmd_full,
    input logic       wr_push,
    input logic       wr_full,
    input logic       rd_push,
    input logic       rd_full
);
    a_sck_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(sck) |-> !$past(cs)) else $error("sck toggled with cs high");

    a_oe_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cs |-> (sio_oe == 4'b0000)) else $error("sio_oe active with cs high");

    a_cmd_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd_push && cmd_full)) else $error("push into full command fifo");

    a_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_push && wr_full)) else $error("push into full write fifo");

    a_rd_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_push && rd_full)) else $error("push into full read fifo");

endmodule

bind spi_sram_fifo sram_assertions u_chk (
    .clk(clk), .rst_n(rst_n), .cs(cs), .sck(sck), .sio_oe(sio_oe),
    .cmd_push(cmd_valid), .cmd_full(cmd_full),
    .wr_push(wr_valid), .wr_full(wr_full),
    .rd_push(rd_push), .rd_full(rd_full)
);

/* verif/tb_sram_test_top.sv */
`timescale 1ns/10ps

module tb_sram_test_top;

    localparam int run_limit = 5000;   // clocks per self-test run

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [23:0]        base_addr;
    sram_if_pkg::word_t pattern;
    logic               busy;
    logic               pass;
    logic               fail;
    logic               cs;
    logic               sck;
    logic [3:0]         sio_o;
    logic [3:0]         sio_oe;
    logic [3:0]         sio_i;
    logic               flip_req;
    logic [4:0]         flip_bit;

    logic [31:0] lfsr;
    logic [15:0] cur_addr;
    logic [31:0] cur_pattern;
    logic        cur_flip;
    logic [4:0]  cur_flip_bit;
    logic        busy_q;
    int          checks_done;
    int          err_count;
    int          timeout_count;

    sram_test_top dut (
        .clk(clk), .rst_n(rst_n),
        .start(start), .base_addr(base_addr), .pattern(pattern),
        .busy(busy), .pass(pass), .fail(fail),
        .cs(cs), .sck(sck), .sio_o(sio_o), .sio_oe(sio_oe), .sio_i(sio_i)
    );

    qspi_sram_model model (
        .cs(cs), .sck(sck), .sio_o(sio_o), .sio_oe(sio_oe), .sio_i(sio_i),
        .flip_req(flip_req), .flip_bit(flip_bit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference and random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] expected_word(input logic [31:0] pat, input int i);
        return pat + 32'(i);   // wraps at 32 bits
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] stored_word(input int a);
        return {model.read_byte(a), model.read_byte(a + 1),
                model.read_byte(a + 2), model.read_byte(a + 3)};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comparison at the end of each run
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic compare_run();
        logic [31:0] got;
        logic [31:0] exp;
        for (int i = 0; i < sram_cfg_pkg::test_words; i++) begin
            got = stored_word(int'(cur_addr) + 4 * i);
            exp = expected_word(cur_pattern, i);
            if (cur_flip && i == 0) begin
                exp = exp ^ (32'h1 << cur_flip_bit);   // model flips a bit of the first word
            end
            assert (got == exp) else begin
                err_count++;
                $display("ERR %0t: word %0d at %h is %h, expected %h",
                         $time, i, cur_addr, got, exp);
            end
        end
        assert (pass == !cur_flip && fail == cur_flip) else begin
            err_count++;
            $display("ERR %0t: pass=%b fail=%b, expected pass=%b", $time, pass, fail,
                     !cur_flip);
        end
        checks_done++;
    endtask

    always @(negedge clk) begin
        if (rst_n && busy_q && !busy) compare_run();
        busy_q <= busy;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_once(input int n, input logic flip, output logic ok);
        logic [31:0] a;
        logic [31:0] p;
        logic [31:0] b;
        int          seen;
        int          cycles;
        take_bits(16, a);
        take_bits(32, p);
        take_bits(5, b);
        cur_addr     = a[15:0];
        cur_pattern  = p;
        cur_flip     = flip;
        cur_flip_bit = b[4:0];
        seen         = checks_done;
        cycles       = 0;
        @(posedge clk);
        start     <= 1'b1;
        base_addr <= {8'h00, a[15:0]};
        pattern   <= p;
        flip_req  <= flip;
        flip_bit  <= b[4:0];
        @(posedge clk);
        start <= 1'b0;
        while (checks_done == seen && cycles < run_limit) begin
            @(posedge clk);
            cycles++;
        end
        flip_req <= 1'b0;
        ok = (checks_done != seen);
        if (!ok) begin
            timeout_count++;
            $display("timeout: self-test run %0d never dropped busy", n);
        end
    endtask

    task automatic run_all();
        int   cycles;
        logic ok;
        cycles = 0;
        while (model.n_eqio == 0 && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (model.n_eqio == 0) begin
            timeout_count++;
            $display("timeout: enter-quad-mode never reached the SRAM model");
            return;
        end
        assert (model.first_byte == sram_cfg_pkg::cmd_eqio && model.first_oe == 4'b0001)
        else begin
            err_count++;
            $display("ERR %0t: first byte %h oe=%b", $time, model.first_byte,
                     model.first_oe);
        end
        for (int n = 0; n < 6; n++) begin
            run_once(n, n == 4, ok);   // run 4 corrupts the stored data
            if (!ok) return;
        end
        assert (model.n_eqio == 1 && model.n_write == 6 && model.n_read == 6) else begin
            err_count++;
            $display("ERR %0t: opcode counts eqio=%0d write=%0d read=%0d", $time,
                     model.n_eqio, model.n_write, model.n_read);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        start         = 1'b0;
        base_addr     = '0;
        pattern       = '0;
        flip_req      = 1'b0;
        flip_bit      = '0;
        busy_q        = 1'b0;
        lfsr          = 32'hc990;
        checks_done   = 0;
        err_count     = 0;
        timeout_count = 0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        assert (cs && !sck && sio_oe == 4'b0000 && !pass && !fail && !busy) else begin
            err_count++;
            $display("ERR %0t: bad reset state cs=%b sck=%b oe=%b pass=%b fail=%b busy=%b",
                     $time, cs, sck, sio_oe, pass, fail, busy);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        run_all();
        $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* list.f */
logic/sram_cfg_pkg.sv
logic/sram_if_pkg.sv
logic/word_fifo.sv
logic/qspi_shifter.sv
logic/sram_sequencer.sv
logic/spi_sram_fifo.sv
logic/sram_self_test.sv
logic/sram_test_top.sv
verif/qspi_sram_model.sv
verif/sram_assertions.sv
verif/tb_sram_test_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sram_test_top -f list.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
grep -q "Regression passed" sim.log
